// File: exec_stage.f
+incdir+include
hw/exec_pkg.sv
hw/exec_alu.sv
hw/branch_resolve.sv
hw/exec_lane.sv
hw/exec_stage.sv
verification/exec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f exec_stage.f --top-module exec_tb -o exec_sim \
    && ./obj_dir/exec_sim 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -q "tests failed" sim.log && exit 1 || exit 0

// File: include/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// returns {overflow, result}
function automatic logic [32:0] model_alu(
    input exec_pkg::word_t   a,
    input exec_pkg::word_t   b,
    input exec_pkg::alu_op_e op
);
    logic [32:0]     sum;
    logic [32:0]     dif;
    exec_pkg::word_t y;
    logic            ovf;

    // one extra sign bit shows signed overflow
    sum = {a[31], a} + {b[31], b};
    dif = {a[31], a} - {b[31], b};
    ovf = 1'b0;
    case (op)
        exec_pkg::ADD: begin
            y   = sum[31:0];
            ovf = sum[32] ^ sum[31];
        end
        exec_pkg::SUB: begin
            y   = dif[31:0];
            ovf = dif[32] ^ dif[31];
        end
        exec_pkg::ADDU: y = sum[31:0];
        exec_pkg::SUBU: y = dif[31:0];
        exec_pkg::AND:  y = a & b;
        exec_pkg::OR:   y = a | b;
        exec_pkg::XOR:  y = a ^ b;
        exec_pkg::NOR:  y = ~(a | b);
        exec_pkg::SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exec_pkg::SLTU: y = (a < b) ? 32'd1 : 32'd0;
        exec_pkg::SLL:  y = b << a[4:0];
        exec_pkg::SRL:  y = b >> a[4:0];
        exec_pkg::SRA:  y = $unsigned($signed(b) >>> a[4:0]);
        exec_pkg::LUI:  y = b << 16;
        default:        y = '0;
    endcase
    return {ovf, y};
endfunction

// one lane before any cross-lane squash
function automatic exec_pkg::result_t model_lane(
    input exec_pkg::issue_t  iss,
    input exec_pkg::bypass_t byp_a,
    input exec_pkg::bypass_t byp_b
);
    exec_pkg::result_t r;
    exec_pkg::word_t   rs;
    exec_pkg::word_t   rt;
    exec_pkg::word_t   ext;
    logic [32:0]       alu;
    logic              bad;
    logic              cm_fail;

    rs  = byp_a.bypass ? byp_a.data : iss.rd1;
    rt  = byp_b.bypass ? byp_b.data : iss.rd2;
    ext = iss.ctl.zero_ext ? {16'b0, iss.imm} : {{16{iss.imm[15]}}, iss.imm};
    alu = model_alu(iss.ctl.shamt_valid ? {27'b0, iss.raw_instr[10:6]} : rs,
                    iss.ctl.imm_src ? ext : rt, iss.ctl.alu_op);
    bad = ((iss.ctl.msize == exec_pkg::MSIZE2) && alu[0])
        || ((iss.ctl.msize == exec_pkg::MSIZE4) && (alu[1:0] != 2'b00));
    cm_fail = ((iss.ctl.cmove == exec_pkg::CM_MOVZ) && (rt != 0))
            || ((iss.ctl.cmove == exec_pkg::CM_MOVN) && (rt == 0));
    r              = '0;
    r.valid        = iss.valid;
    r.pc           = iss.pc;
    r.alu_out      = iss.ctl.is_link ? iss.pc + 32'd8 : alu[31:0];
    r.srca         = rs;
    r.srcb         = rt;
    r.rdst         = iss.rdst;
    r.regwrite     = iss.ctl.regwrite && !cm_fail;
    r.memtoreg     = iss.ctl.memtoreg && !bad;
    r.memwrite     = iss.ctl.memwrite && !bad;
    r.msize        = iss.ctl.msize;
    r.exc.overflow = alu[32];
    r.exc.adel     = iss.ctl.memtoreg && bad;
    r.exc.ades     = iss.ctl.memwrite && bad;
    r.exc.trap     = iss.ctl.tne && (rs == rt);
    return r;
endfunction

// lane-1 branch and jump outcome
function automatic void model_branch(
    input  exec_pkg::issue_t iss,
    input  exec_pkg::word_t  rs,
    input  exec_pkg::word_t  rt,
    output logic             cond,
    output logic             redirect,
    output exec_pkg::word_t  target
);
    logic t;

    case (iss.ctl.branch_type)
        exec_pkg::BEQ:  t = (rs == rt);
        exec_pkg::BNE:  t = (rs != rt);
        exec_pkg::BGEZ: t = ($signed(rs) >= 0);
        exec_pkg::BGTZ: t = ($signed(rs) > 0);
        exec_pkg::BLEZ: t = ($signed(rs) <= 0);
        exec_pkg::BLTZ: t = ($signed(rs) < 0);
        default:        t = 1'b0;
    endcase
    cond   = iss.ctl.branch && t;
    target = '0;
    if (iss.ctl.branch && cond && !iss.pre_taken) begin
        target = iss.pc + 32'd4 + {{14{iss.raw_instr[15]}}, iss.raw_instr[15:0], 2'b00};
    end else if (iss.ctl.branch && !cond && iss.pre_taken) begin
        target = iss.pc + 32'd8;
    end else if (iss.ctl.jr) begin
        target = rs;
    end else if (iss.ctl.jump) begin
        target = {iss.pc[31:28] + {3'b0, (iss.pc[27:0] > 28'hffffffb)},
                  iss.raw_instr[25:0], 2'b00};
    end
    redirect = iss.valid
        && ((iss.ctl.branch && (cond != iss.pre_taken))
        || ((iss.ctl.jump || iss.ctl.jr) && !(iss.pre_taken && (iss.pre_pc == target))));
endfunction

`endif

// File: verification/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;
    import exec_pkg::*;

    `include "exec_model.svh"

    typedef struct packed {
        result_t [1:0] res;
        logic          cond;
        logic          redir;
        word_t         tgt;
    } expect_t;

    logic              clk = 1'b0;
    logic              rst_i;
    issue_t  [1:0]     issue_i;
    bypass_t [1:0]     bypass_a_i;
    bypass_t [1:0]     bypass_b_i;
    result_t [1:0]     result_o;
    logic              redirect_o;
    word_t             redirect_pc_o;
    logic              branch_cond_o;
    logic [15:0]       lfsr;
    expect_t           exp_q[$];
    int                tests_run = 0;
    int                tests_bad = 0;
    logic              reset_ok;

    exec_stage i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_i       (issue_i),
        .bypass_a_i    (bypass_a_i),
        .bypass_b_i    (bypass_b_i),
        .result_o      (result_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .branch_cond_o (branch_cond_o)
    );

    always #4 clk = ~clk;

    initial begin
        rst_i = 1'b1;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
    end

    // galois lfsr, one step per bit drawn
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    // random instruction, shaped by the feature under test
    function automatic issue_t make_issue(input int mode, input int lane);
        issue_t     s;
        logic [1:0] pick;
        s = '0;
        s.valid        = (rand_bits(2) != 32'd0);
        s.pc           = rand_bits(30) << 2;
        s.raw_instr    = rand_bits(32);
        s.rd1          = rand_bits(32);
        s.rd2          = rand_bits(32);
        s.imm          = 16'(rand_bits(16));
        s.rdst         = 5'(rand_bits(5));
        s.ctl.regwrite = rand_bit();
        s.ctl.alu_op   = alu_op_e'(4'(rand_bits(4) % 32'd14));
        case (mode)
            1: begin
                if (rand_bit()) begin
                    s.ctl.alu_op = rand_bit() ? ADD : SUB;
                end
            end
            2: begin
                s.ctl.imm_src     = rand_bit();
                s.ctl.zero_ext    = rand_bit();
                s.ctl.shamt_valid = rand_bit();
            end
            3: begin
                if (lane == 1) begin
                    pick                = 2'(rand_bits(2));
                    s.ctl.branch        = (pick < 2'd2);
                    s.ctl.jump          = (pick == 2'd2);
                    s.ctl.jr            = (pick == 2'd3);
                    s.ctl.branch_type   = branch_e'(3'(rand_bits(3) % 32'd6));
                    s.pre_taken         = rand_bit();
                    s.pre_pc            = rand_bits(30) << 2;
                    if (rand_bits(2) == 32'd0) begin
                        s.rd1 = '0;
                    end
                    if (rand_bit()) begin
                        s.rd2 = s.rd1;
                    end
                end
            end
            4: begin
                // address is rs plus the immediate
                s.ctl.alu_op   = ADDU;
                s.ctl.imm_src  = 1'b1;
                s.ctl.memtoreg = rand_bit();
                s.ctl.memwrite = !s.ctl.memtoreg && rand_bit();
                s.ctl.msize    = msize_e'(2'(rand_bits(2) % 32'd3));
                s.ctl.tne      = rand_bit();
                if (rand_bit()) begin
                    s.rd2 = s.rd1;
                end
                s.in_exc = (lane == 1) && (rand_bits(2) == 32'd0);
            end
            5: begin
                s.ctl.alu_op  = OR;
                s.ctl.cmove   = cmove_e'(2'(rand_bits(2) % 32'd3));
                s.ctl.is_link = (rand_bits(2) == 32'd0);
                if (rand_bit()) begin
                    s.rd2 = '0;
                end
            end
            default: begin
            end
        endcase
        return s;
    endfunction

    task automatic run_test(input string name, input int mode, input int count);
        issue_t  [1:0] iss;
        bypass_t [1:0] ba;
        bypass_t [1:0] bb;
        expect_t       e;
        expect_t       got;
        int            checks;
        int            errs;
        checks = 0;
        errs   = 0;
        exp_q.delete();
        for (int n = 0; n <= count; n++) begin
            @(posedge clk);
            iss = '0;
            ba  = '0;
            bb  = '0;
            if (n < count) begin
                for (int l = 0; l < 2; l++) begin
                    iss[l]       = make_issue(mode, l);
                    ba[l].bypass = (mode == 2) ? rand_bit() : (rand_bits(3) == 32'd0);
                    ba[l].data   = rand_bits(32);
                    bb[l].bypass = (mode == 2) ? rand_bit() : (rand_bits(3) == 32'd0);
                    bb[l].data   = rand_bits(32);
                end
            end
            e.res[1] = model_lane(iss[1], ba[1], bb[1]);
            e.res[0] = model_lane(iss[0], ba[0], bb[0]);
            model_branch(iss[1], e.res[1].srca, e.res[1].srcb, e.cond, e.redir, e.tgt);
            // a predictor that already points at the target
            if (mode == 3 && rand_bit()) begin
                iss[1].pre_pc = e.tgt;
                model_branch(iss[1], e.res[1].srca, e.res[1].srcb, e.cond, e.redir, e.tgt);
            end
            // older lane squashes the younger one
            if (iss[1].valid && e.res[1].exc.overflow) begin
                e.res[0].valid = 1'b0;
            end
            if (iss[1].valid && (iss[1].in_exc || (e.res[1].exc != '0))) begin
                e.res[0].memtoreg = 1'b0;
                e.res[0].memwrite = 1'b0;
            end
            exp_q.push_back(e);
            issue_i    <= iss;
            bypass_a_i <= ba;
            bypass_b_i <= bb;
            @(negedge clk);
            if (exp_q.size() >= 2) begin
                e   = exp_q.pop_front();
                got = {result_o, branch_cond_o, redirect_o, redirect_pc_o};
                checks++;
                for (int l = 0; l < 2; l++) begin
                    if (got.res[l] !== e.res[l]) begin
                        $display("error %s: lane %0d expected %h actual %h",
                                 name, l, e.res[l], got.res[l]);
                        errs++;
                    end
                end
                if ({got.cond, got.redir, got.tgt} !== {e.cond, e.redir, e.tgt}) begin
                    $display("error %s: branch expected %h actual %h",
                             name, {e.cond, e.redir, e.tgt}, {got.cond, got.redir, got.tgt});
                    errs++;
                end
            end
        end
        $display("test %s: %0d checks, %0d errors", name, checks, errs);
        tests_run++;
        if (errs != 0) begin
            tests_bad++;
        end
    endtask

    task automatic check_reset(output logic ok);
        int errs;
        int waited;
        errs   = 0;
        waited = 0;
        ok     = 1'b1;
        @(negedge clk);
        while (rst_i && waited < 40) begin
            if ({result_o[1].valid, result_o[0].valid, redirect_o} !== 3'b000) begin
                $display("error reset_latency: expected 000 actual %b",
                         {result_o[1].valid, result_o[0].valid, redirect_o});
                errs++;
            end
            @(posedge clk);
            if (waited == 4) begin
                // strobes stop well before reset is released
                issue_i <= '0;
            end
            @(negedge clk);
            waited++;
        end
        if (rst_i) begin
            $display("reset was still asserted after %0d cycles", waited);
            ok = 1'b0;
        end else begin
            // first edge that sees reset low
            @(negedge clk);
            if ({result_o[1].valid, result_o[0].valid, redirect_o} !== 3'b000) begin
                $display("error reset_latency: expected 000 actual %b",
                         {result_o[1].valid, result_o[0].valid, redirect_o});
                errs++;
            end
            $display("test reset_latency: %0d cycles in reset, %0d errors", waited, errs);
            tests_run++;
            if (errs != 0) begin
                tests_bad++;
            end
        end
    endtask

    initial begin
        issue_i    = '0;
        bypass_a_i = '0;
        bypass_b_i = '0;
        // valid strobes and a mispredicted jump while reset is held
        issue_i[0].valid    = 1'b1;
        issue_i[1].valid    = 1'b1;
        issue_i[1].ctl.jump = 1'b1;
        lfsr       = 16'd48631;
        check_reset(reset_ok);
        if (reset_ok) begin
            run_test("alu", 1, 300);
            run_test("operands", 2, 300);
            run_test("branch", 3, 400);
            run_test("align_trap", 4, 300);
            run_test("cmove_link", 5, 300);
        end
        $display("totals: %0d run, %0d with errors", tests_run, tests_bad);
        if (reset_ok && tests_bad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: hw/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                    clk,
    input  logic                    rst_i,
    input  exec_pkg::issue_t  [1:0] issue_i,
    input  exec_pkg::bypass_t [1:0] bypass_a_i,
    input  exec_pkg::bypass_t [1:0] bypass_b_i,
    output exec_pkg::result_t [1:0] result_o,
    output logic                    redirect_o,
    output exec_pkg::word_t         redirect_pc_o,
    output logic                    branch_cond_o
);
    import exec_pkg::*;

    result_t [1:0] lane_res;
    word_t   [1:0] lane_rs;
    word_t   [1:0] lane_rt;
    result_t [1:0] res_d;
    result_t [1:0] res_q;
    logic    [1:0] valid_q;
    logic          br_cond;
    logic          br_redirect;
    word_t         br_target;
    logic          l1_ovf;
    logic          l1_exc;
    logic          redirect_q;
    logic          cond_q;
    word_t         target_q;

    for (genvar i = 0; i < 2; i++) begin : g_lane
        exec_lane i_lane (
            .issue_i    (issue_i[i]),
            .bypass_a_i (bypass_a_i[i]),
            .bypass_b_i (bypass_b_i[i]),
            .result_o   (lane_res[i]),
            .rs_o       (lane_rs[i]),
            .rt_o       (lane_rt[i])
        );
    end

    // only lane 1 carries control flow
    branch_resolve i_branch (
        .issue_i    (issue_i[1]),
        .rs_i       (lane_rs[1]),
        .rt_i       (lane_rt[1]),
        .cond_o     (br_cond),
        .redirect_o (br_redirect),
        .target_o   (br_target)
    );

    assign l1_ovf = issue_i[1].valid && lane_res[1].exc.overflow;
    assign l1_exc = issue_i[1].valid && (issue_i[1].in_exc || (|lane_res[1].exc));

    // the older lane faulting squashes the younger one
    always_comb begin
        res_d = lane_res;
        if (l1_ovf) begin
            res_d[0].valid = 1'b0;
        end
        if (l1_exc) begin
            res_d[0].memtoreg = 1'b0;
            res_d[0].memwrite = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q    <= '0;
            redirect_q <= 1'b0;
            cond_q     <= 1'b0;
        end else begin
            valid_q    <= {res_d[1].valid, res_d[0].valid};
            redirect_q <= br_redirect;
            cond_q     <= br_cond;
        end
    end

    always_ff @(posedge clk) begin
        res_q    <= res_d;
        target_q <= br_target;
    end

    // registered payload with the reset-cleared valid bits
    always_comb begin
        result_o          = res_q;
        result_o[0].valid = valid_q[0];
        result_o[1].valid = valid_q[1];
    end

    assign redirect_o    = redirect_q;
    assign redirect_pc_o = target_q;
    assign branch_cond_o = cond_q;

endmodule

// File: hw/exec_lane.sv
`timescale 1ns/1ps

module exec_lane (
    input  exec_pkg::issue_t  issue_i,
    input  exec_pkg::bypass_t bypass_a_i,
    input  exec_pkg::bypass_t bypass_b_i,
    output exec_pkg::result_t result_o,
    output exec_pkg::word_t   rs_o,
    output exec_pkg::word_t   rt_o
);
    import exec_pkg::*;

    ctl_t  ctl;
    word_t rs;
    word_t rt;
    word_t imm_ext;
    word_t op_a;
    word_t op_b;
    word_t alu_y;
    logic  alu_ovf;
    logic  addr_bad;
    logic  cm_fail;

    assign ctl = issue_i.ctl;

    // forwarded values win over the register file read
    assign rs = bypass_a_i.bypass ? bypass_a_i.data : issue_i.rd1;
    assign rt = bypass_b_i.bypass ? bypass_b_i.data : issue_i.rd2;

    assign rs_o = rs;
    assign rt_o = rt;

    assign imm_ext = ext_imm(issue_i.imm, ctl.zero_ext);

    // sll/srl/sra take the amount from the instruction word
    assign op_a = ctl.shamt_valid ? {27'b0, issue_i.raw_instr[10:6]} : rs;
    assign op_b = ctl.imm_src ? imm_ext : rt;

    exec_alu i_alu (
        .a_i        (op_a),
        .b_i        (op_b),
        .op_i       (ctl.alu_op),
        .y_o        (alu_y),
        .overflow_o (alu_ovf)
    );

    // effective address is the raw alu result
    assign addr_bad = misaligned(ctl.msize, alu_y[1:0]);

    always_comb begin
        case (ctl.cmove)
            CM_MOVZ: cm_fail = (rt != '0);
            CM_MOVN: cm_fail = (rt == '0);
            default: cm_fail = 1'b0;
        endcase
    end

    always_comb begin
        result_o.valid   = issue_i.valid;
        result_o.pc      = issue_i.pc;
        result_o.alu_out = alu_y;
        if (ctl.is_link) begin
            // return address skips the delay slot
            result_o.alu_out = issue_i.pc + LINK_OFFSET;
        end
        result_o.srca     = rs;
        result_o.srcb     = rt;
        result_o.rdst     = issue_i.rdst;
        result_o.regwrite = ctl.regwrite && !cm_fail;
        result_o.memtoreg = ctl.memtoreg && !addr_bad;
        result_o.memwrite = ctl.memwrite && !addr_bad;
        result_o.msize    = ctl.msize;

        result_o.exc.overflow = alu_ovf;
        result_o.exc.adel     = ctl.memtoreg && addr_bad;
        result_o.exc.ades     = ctl.memwrite && addr_bad;
        result_o.exc.trap     = ctl.tne && (rs == rt);
    end

endmodule

// File: hw/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  exec_pkg::issue_t issue_i,
    input  exec_pkg::word_t  rs_i,
    input  exec_pkg::word_t  rt_i,
    output logic             cond_o,
    output logic             redirect_o,
    output exec_pkg::word_t  target_o
);
    import exec_pkg::*;

    ctl_t  ctl;
    word_t slot_pc;
    word_t br_offset;
    logic  rs_zero;
    logic  taken;
    logic  is_jmp;
    logic  br_miss;
    logic  jmp_miss;

    assign ctl     = issue_i.ctl;
    assign slot_pc = issue_i.pc + SLOT_OFFSET;
    assign rs_zero = (rs_i == '0);

    // word offset relative to the delay slot
    assign br_offset = {{14{issue_i.raw_instr[15]}}, issue_i.raw_instr[15:0], 2'b00};

    always_comb begin
        case (ctl.branch_type)
            BEQ:     taken = (rs_i == rt_i);
            BNE:     taken = (rs_i != rt_i);
            BGEZ:    taken = !rs_i[31];
            BGTZ:    taken = !rs_i[31] && !rs_zero;
            BLEZ:    taken = rs_i[31] || rs_zero;
            BLTZ:    taken = rs_i[31];
            default: taken = 1'b0;
        endcase
    end

    assign cond_o = ctl.branch && taken;
    assign is_jmp = ctl.jump || ctl.jr;

    // a correctly predicted branch needs no target
    always_comb begin
        if (ctl.branch && cond_o && !issue_i.pre_taken) begin
            target_o = slot_pc + br_offset;
        end else if (ctl.branch && !cond_o && issue_i.pre_taken) begin
            // fall through past the delay slot
            target_o = issue_i.pc + LINK_OFFSET;
        end else if (ctl.jr) begin
            target_o = rs_i;
        end else if (ctl.jump) begin
            target_o = {slot_pc[31:28], issue_i.raw_instr[25:0], 2'b00};
        end else begin
            target_o = '0;
        end
    end

    assign br_miss = ctl.branch && (cond_o != issue_i.pre_taken);

    // jumps are fine only if the predictor already went to the same place
    assign jmp_miss = is_jmp && !(issue_i.pre_taken && (issue_i.pre_pc == target_o));

    assign redirect_o = issue_i.valid && (br_miss || jmp_miss);

endmodule

// File: hw/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::word_t   a_i,
    input  exec_pkg::word_t   b_i,
    input  exec_pkg::alu_op_e op_i,
    output exec_pkg::word_t   y_o,
    output logic              overflow_o
);
    import exec_pkg::*;

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    logic       add_ovf;
    logic       sub_ovf;

    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;
    assign shamt = a_i[4:0];

    // same-sign operands giving a result of the other sign
    assign add_ovf = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
    // for subtract the operand signs must differ
    assign sub_ovf = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);

    always_comb begin
        y_o        = '0;
        overflow_o = 1'b0;
        case (op_i)
            ADD: begin
                y_o        = sum;
                overflow_o = add_ovf;
            end
            ADDU: begin
                y_o = sum;
            end
            SUB: begin
                y_o        = diff;
                overflow_o = sub_ovf;
            end
            SUBU: begin
                y_o = diff;
            end
            AND: begin
                y_o = a_i & b_i;
            end
            OR: begin
                y_o = a_i | b_i;
            end
            XOR: begin
                y_o = a_i ^ b_i;
            end
            NOR: begin
                y_o = ~(a_i | b_i);
            end
            SLT: begin
                y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            end
            SLTU: begin
                y_o = {31'b0, a_i < b_i};
            end
            // shifts move B by the amount held in A
            SLL: begin
                y_o = b_i << shamt;
            end
            SRL: begin
                y_o = b_i >> shamt;
            end
            SRA: begin
                y_o = word_t'($signed(b_i) >>> shamt);
            end
            LUI: begin
                y_o = {b_i[15:0], 16'b0};
            end
            default: begin
                y_o = '0;
            end
        endcase
    end

endmodule

// File: hw/exec_pkg.sv
package exec_pkg;

    localparam int IMM_W       = 16;
    localparam int LINK_OFFSET = 8;
    localparam int SLOT_OFFSET = 4;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BGEZ,
        BGTZ,
        BLEZ,
        BLTZ
    } branch_e;

    typedef enum logic [1:0] {
        MSIZE1,
        MSIZE2,
        MSIZE4
    } msize_e;

    typedef enum logic [1:0] {
        CM_NONE,
        CM_MOVZ,
        CM_MOVN
    } cmove_e;

    // decoded control from the issue stage
    typedef struct packed {
        alu_op_e alu_op;
        logic    imm_src;
        logic    zero_ext;
        logic    shamt_valid;
        logic    memtoreg;
        logic    memwrite;
        msize_e  msize;
        logic    regwrite;
        logic    tne;
        cmove_e  cmove;
        logic    is_link;
        logic    branch;
        branch_e branch_type;
        logic    jump;
        logic    jr;
    } ctl_t;

    typedef struct packed {
        logic overflow;
        logic adel;
        logic ades;
        logic trap;
    } exc_t;

    typedef struct packed {
        logic  bypass;
        word_t data;
    } bypass_t;

    typedef struct packed {
        logic             valid;
        word_t            pc;
        word_t            raw_instr;
        word_t            rd1;
        word_t            rd2;
        logic [IMM_W-1:0] imm;
        reg_idx_t         rdst;
        ctl_t             ctl;
        logic             pre_taken;
        word_t            pre_pc;
        logic             in_exc;
    } issue_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    alu_out;
        word_t    srca;
        word_t    srcb;
        reg_idx_t rdst;
        logic     regwrite;
        logic     memtoreg;
        logic     memwrite;
        msize_e   msize;
        exc_t     exc;
    } result_t;

    // 16-bit immediate widened to a word
    function automatic word_t ext_imm(logic [IMM_W-1:0] imm, logic zero_ext);
        if (zero_ext) begin
            return {{(32-IMM_W){1'b0}}, imm};
        end
        return {{(32-IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

    function automatic logic misaligned(msize_e size, logic [1:0] addr_lo);
        return ((size == MSIZE2) && addr_lo[0]) || ((size == MSIZE4) && (addr_lo != 2'b00));
    endfunction

endpackage
